/* flist.f */
verilog/issue_cfg_pkg.sv
verilog/issue_types_pkg.sv
verilog/dispatch_control.sv
verilog/int_issue_queue.sv
verilog/mem_issue_queue.sv
verilog/issue_top.sv
tb/tb_clock_gen.sv
tb/tb_issue.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the issue stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_issue -f flist.f -o sim_issue

./obj_dir/sim_issue > sim.log 2>&1 || true
cat sim.log

if grep -q "^All tests passed$" sim.log; then
	exit 0
fi
exit 1

/* tb/tb_issue.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_issue;
	import issue_cfg_pkg::*;
	import issue_types_pkg::*;

	localparam int ID = INT_QUEUE_DEPTH_DEFAULT;
	localparam int MD = MEM_QUEUE_DEPTH_DEFAULT;

	logic clk, rst_n;
	logic v [ISSUE_WIDTH], is_mem [ISSUE_WIDTH], rs_rdy [ISSUE_WIDTH], rt_rdy [ISSUE_WIDTH];
	logic u_rs [ISSUE_WIDTH], u_rt [ISSUE_WIDTH], u_imm [ISSUE_WIDTH];
	phys_reg_t rs [ISSUE_WIDTH], rt [ISSUE_WIDTH];
	data_t imm [ISSUE_WIDTH];
	mem_action_t act [ISSUE_WIDTH];
	active_id_t aid [ISSUE_WIDTH];
	logic alu_v, load_v, int_rel_v, mem_rel_v;
	phys_reg_t alu_reg, load_reg;
	logic [2:0] int_rel_idx, int_rd_idx;
	logic [1:0] mem_rel_idx, mem_rd_idx;
	logic stall;
	logic [ID-1:0] int_busy, int_ready;
	logic [MD-1:0] mem_busy, mem_ready;
	phys_reg_t int_src1, int_src2, mem_base, mem_store;
	data_t int_imm, mem_imm;
	active_id_t int_aid, mem_aid;
	mem_action_t mem_act;

	// Reference state of both queues
	logic [ID-1:0] m_ib, m_ir1, m_ir2;
	logic [MD-1:0] m_mb, m_mr1, m_mr2;
	phys_reg_t m_is1 [ID], m_is2 [ID], m_ms1 [MD], m_ms2 [MD];
	data_t m_iimm [ID], m_mimm [MD];
	active_id_t m_iaid [ID], m_maid [MD];
	mem_action_t m_mact [MD];
	int errors = 0;

	tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(16)) u_clk (.clk(clk), .rst_n(rst_n));

	issue_top #(.INT_DEPTH(ID), .MEM_DEPTH(MD)) uut (
		.clk(clk), .rst_n(rst_n), .i_valid(v), .i_is_mem(is_mem), .i_rs(rs),
		.i_rs_ready(rs_rdy), .i_rt(rt), .i_rt_ready(rt_rdy), .i_uses_rs(u_rs),
		.i_uses_rt(u_rt), .i_uses_imm(u_imm), .i_imm(imm), .i_mem_action(act),
		.i_active_id(aid), .i_alu_wb_valid(alu_v), .i_alu_wb_reg(alu_reg),
		.i_load_wb_valid(load_v), .i_load_wb_reg(load_reg),
		.i_int_release_valid(int_rel_v), .i_int_release_idx(int_rel_idx),
		.i_mem_release_valid(mem_rel_v), .i_mem_release_idx(mem_rel_idx),
		.i_int_rd_idx(int_rd_idx), .i_mem_rd_idx(mem_rd_idx), .o_stall(stall),
		.o_int_busy(int_busy), .o_int_ready(int_ready), .o_mem_busy(mem_busy),
		.o_mem_ready(mem_ready), .o_int_rd_src1(int_src1), .o_int_rd_src2(int_src2),
		.o_int_rd_imm(int_imm), .o_int_rd_active_id(int_aid), .o_mem_rd_base(mem_base),
		.o_mem_rd_store_src(mem_store), .o_mem_rd_imm(mem_imm),
		.o_mem_rd_action(mem_act), .o_mem_rd_active_id(mem_aid)
	);

	function automatic int free_count(input logic [7:0] busy, input int depth);
		int n;
		n = 0;
		for (int e = 0; e < depth; e++)
			if (!busy[e])
				n++;
		return (n > 2) ? 2 : n;
	endfunction

	function automatic int lowest_free(input logic [7:0] busy, input int depth);
		for (int e = 0; e < depth; e++)
			if (!busy[e])
				return e;
		return 0;
	endfunction

	function automatic int highest_free(input logic [7:0] busy, input int depth);
		for (int e = depth - 1; e >= 0; e--)
			if (!busy[e])
				return e;
		return 0;
	endfunction

	// Whole group waits if either queue lacks room
	function automatic logic expected_stall();
		int ni, nm;
		ni = 0;
		nm = 0;
		for (int s = 0; s < ISSUE_WIDTH; s++)
			if (v[s])
			begin
				if (is_mem[s])
					nm++;
				else
					ni++;
			end
		return (ni > free_count(8'(m_ib), ID)) || (nm > free_count(8'(m_mb), MD));
	endfunction

	function automatic logic woken(input phys_reg_t r);
		return (alu_v && alu_reg == r) || (load_v && load_reg == r);
	endfunction

	// Advances both reference queues by one clock edge
	function automatic void model_step();
		logic [ID-1:0] ib;
		logic [MD-1:0] mb;
		int idx;
		logic st;
		ib = m_ib;
		mb = m_mb;
		st = expected_stall();
		for (int e = 0; e < ID; e++)
			if (m_ib[e])
			begin
				m_ir1[e] = m_ir1[e] | woken(m_is1[e]);
				m_ir2[e] = m_ir2[e] | woken(m_is2[e]);
			end
		for (int e = 0; e < MD; e++)
			if (m_mb[e])
			begin
				m_mr1[e] = m_mr1[e] | woken(m_ms1[e]);
				m_mr2[e] = m_mr2[e] | woken(m_ms2[e]);
			end
		if (int_rel_v)
			m_ib[int_rel_idx] = 1'b0;
		if (mem_rel_v)
			m_mb[mem_rel_idx] = 1'b0;
		// Allocation picks from the masks before this edge
		for (int s = 0; s < ISSUE_WIDTH && !st; s++)
		begin
			if (v[s] && !is_mem[s])
			begin
				idx = (s == 0) ? lowest_free(8'(ib), ID) : highest_free(8'(ib), ID);
				m_ib[idx] = 1'b1;
				m_is1[idx] = rs[s];
				m_is2[idx] = rt[s];
				m_iimm[idx] = u_imm[s] ? imm[s] : '0;
				m_iaid[idx] = aid[s];
				m_ir1[idx] = !u_rs[s] || rs_rdy[s] || woken(rs[s]);
				m_ir2[idx] = !u_rt[s] || rt_rdy[s] || woken(rt[s]);
			end
			else if (v[s])
			begin
				idx = (s == 0) ? lowest_free(8'(mb), MD) : highest_free(8'(mb), MD);
				m_mb[idx] = 1'b1;
				m_ms1[idx] = rs[s];
				m_ms2[idx] = rt[s];
				m_mimm[idx] = imm[s];
				m_mact[idx] = act[s];
				m_maid[idx] = aid[s];
				m_mr1[idx] = !u_rs[s] || rs_rdy[s] || woken(rs[s]);
				m_mr2[idx] = !u_rt[s] || rt_rdy[s] || woken(rt[s]);
			end
		end
	endfunction

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			m_ib = '0;
			m_ir1 = '0;
			m_ir2 = '0;
			m_mb = '0;
			m_mr1 = '0;
			m_mr2 = '0;
		end
		else
			model_step();
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Outputs are settled mid-cycle
	always @(negedge clk)
		if (rst_n)
		begin
			check_val("o_stall", 32'(stall), 32'(expected_stall()));
			check_val("o_int_busy", 32'(int_busy), 32'(m_ib));
			check_val("o_int_ready", 32'(int_ready), 32'(m_ib & m_ir1 & m_ir2));
			check_val("o_mem_busy", 32'(mem_busy), 32'(m_mb));
			check_val("o_mem_ready", 32'(mem_ready), 32'(m_mb & m_mr1 & m_mr2));
			if (m_ib[int_rd_idx])
			begin
				check_val("o_int_rd_src1", 32'(int_src1), 32'(m_is1[int_rd_idx]));
				check_val("o_int_rd_src2", 32'(int_src2), 32'(m_is2[int_rd_idx]));
				check_val("o_int_rd_imm", int_imm, m_iimm[int_rd_idx]);
				check_val("o_int_rd_active_id", 32'(int_aid), 32'(m_iaid[int_rd_idx]));
			end
			if (m_mb[mem_rd_idx])
			begin
				check_val("o_mem_rd_base", 32'(mem_base), 32'(m_ms1[mem_rd_idx]));
				check_val("o_mem_rd_store_src", 32'(mem_store), 32'(m_ms2[mem_rd_idx]));
				check_val("o_mem_rd_imm", mem_imm, m_mimm[mem_rd_idx]);
				check_val("o_mem_rd_action", 32'(mem_act), 32'(m_mact[mem_rd_idx]));
				check_val("o_mem_rd_active_id", 32'(mem_aid), 32'(m_maid[mem_rd_idx]));
			end
		end

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic clear_inputs();
		for (int s = 0; s < ISSUE_WIDTH; s++)
		begin
			v[s] = 0;
			is_mem[s] = 0;
			rs[s] = '0;
			rt[s] = '0;
			rs_rdy[s] = 0;
			rt_rdy[s] = 0;
			u_rs[s] = 0;
			u_rt[s] = 0;
			u_imm[s] = 0;
			imm[s] = '0;
			act[s] = MEM_READ;
			aid[s] = '0;
		end
		alu_v = 0;
		load_v = 0;
		alu_reg = '0;
		load_reg = '0;
		int_rel_v = 0;
		mem_rel_v = 0;
		int_rel_idx = '0;
		mem_rel_idx = '0;
	endtask

	task automatic put_slot(input int s, input logic mem, input int r1, input logic r1_ok,
		input int r2, input logic r2_ok, input logic use_imm, input int value, input int id);
		v[s] = 1;
		is_mem[s] = mem;
		rs[s] = 6'(r1);
		rt[s] = 6'(r2);
		rs_rdy[s] = r1_ok;
		rt_rdy[s] = r2_ok;
		u_rs[s] = (r1 != 0); // Register 0 stands for no source
		u_rt[s] = mem ? value[0] : !use_imm;
		u_imm[s] = use_imm;
		imm[s] = 32'(value);
		aid[s] = 5'(id);
		act[s] = value[0] ? MEM_WRITE : MEM_READ;
	endtask

	initial
	begin
		int n;
		logic held;
		void'($urandom(32'h9502_4bd2));
		clear_inputs();
		int_rd_idx = '0;
		mem_rd_idx = '0;
		n = 0;
		while (!rst_n && n < 40)
		begin
			@(posedge clk);
			n++;
		end
		if (!rst_n)
		begin
			errors++;
			$display("Reset was never released");
		end
		next_cycle();
		check_val("o_int_busy", 32'(int_busy), 32'h0);
		check_val("o_int_ready", 32'(int_ready), 32'h0);
		check_val("o_mem_busy", 32'(mem_busy), 32'h0);
		check_val("o_mem_ready", 32'(mem_ready), 32'h0);
		check_val("o_stall", 32'(stall), 32'h0);
		// Placement, ready at dispatch and same-cycle wakeup
		put_slot(0, 0, 3, 1, 10, 0, 0, 32'h1234, 1);
		put_slot(1, 0, 4, 0, 5, 0, 1, 32'hbeef, 2);
		alu_v = 1;
		alu_reg = 6'd4;
		next_cycle();
		clear_inputs();
		int_rd_idx = 3'd7;
		put_slot(0, 0, 6, 1, 7, 1, 1, 32'h55, 3);
		put_slot(1, 1, 8, 1, 9, 0, 0, 32'h41, 4);
		next_cycle();
		clear_inputs();
		load_v = 1;
		load_reg = 6'd10;
		int_rd_idx = 3'd0;
		mem_rd_idx = 2'd3;
		next_cycle();
		// Fill the memory queue, then overflow it
		clear_inputs();
		put_slot(0, 1, 11, 1, 12, 1, 0, 32'h10, 5);
		put_slot(1, 1, 13, 0, 14, 0, 0, 32'h21, 6);
		next_cycle();
		put_slot(0, 1, 15, 1, 16, 1, 0, 32'h30, 7);
		put_slot(1, 1, 17, 1, 18, 1, 0, 32'h31, 8);
		repeat (2) next_cycle();
		put_slot(0, 0, 19, 1, 20, 1, 1, 32'h77, 9);
		put_slot(1, 0, 21, 1, 22, 1, 1, 32'h78, 10);
		next_cycle();
		// Release and reuse
		clear_inputs();
		mem_rel_v = 1;
		mem_rel_idx = 2'd0;
		int_rel_v = 1;
		int_rel_idx = 3'd0;
		next_cycle();
		clear_inputs();
		put_slot(0, 1, 23, 1, 24, 1, 0, 32'h90, 11);
		mem_rd_idx = 2'd0;
		next_cycle();
		// Random mix, releases only of busy entries
		held = 1'b0;
		for (int c = 0; c < 400; c++)
		begin
			// A stalled group is offered again unchanged
			if (!held)
			begin
				clear_inputs();
				for (int s = 0; s < ISSUE_WIDTH; s++)
					if ($urandom_range(0, 3) != 0)
						put_slot(s, 1'($urandom_range(0, 1)), $urandom_range(0, 15),
							1'($urandom_range(0, 1)), $urandom_range(0, 15),
							1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
							int'($urandom), $urandom_range(0, 31));
			end
			alu_v = 1'($urandom_range(0, 1));
			alu_reg = 6'($urandom_range(0, 15));
			load_v = 1'($urandom_range(0, 1));
			load_reg = 6'($urandom_range(0, 15));
			int_rel_idx = 3'($urandom_range(0, ID - 1));
			int_rel_v = m_ib[int_rel_idx] && ($urandom_range(0, 2) != 0);
			mem_rel_idx = 2'($urandom_range(0, MD - 1));
			mem_rel_v = m_mb[mem_rel_idx] && ($urandom_range(0, 2) != 0);
			int_rd_idx = 3'($urandom_range(0, ID - 1));
			mem_rd_idx = 2'($urandom_range(0, MD - 1));
			@(negedge clk);
			held = stall;
			next_cycle();
		end
		clear_inputs();
		next_cycle();
		$display("Run finished with %0d errors", errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial
	begin
		#(40 * 2000);
		$display("Simulation timed out");
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 rst_n = 1'b1; // Released with the other stimulus, just after an edge
	end

endmodule

`default_nettype wire

/* verilog/issue_top.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_top #(
	parameter int INT_DEPTH = issue_cfg_pkg::INT_QUEUE_DEPTH_DEFAULT,
	parameter int MEM_DEPTH = issue_cfg_pkg::MEM_QUEUE_DEPTH_DEFAULT,
	localparam int INT_IDX_W = $clog2(INT_DEPTH),
	localparam int MEM_IDX_W = $clog2(MEM_DEPTH)
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          i_valid [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                          i_is_mem [issue_cfg_pkg::ISSUE_WIDTH],
	input  issue_types_pkg::phys_reg_t    i_rs [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                          i_rs_ready [issue_cfg_pkg::ISSUE_WIDTH],
	input  issue_types_pkg::phys_reg_t    i_rt [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                          i_rt_ready [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                          i_uses_rs [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                          i_uses_rt [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                          i_uses_imm [issue_cfg_pkg::ISSUE_WIDTH],
	input  issue_types_pkg::data_t        i_imm [issue_cfg_pkg::ISSUE_WIDTH],
	input  issue_types_pkg::mem_action_t  i_mem_action [issue_cfg_pkg::ISSUE_WIDTH],
	input  issue_types_pkg::active_id_t   i_active_id [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                          i_alu_wb_valid,
	input  issue_types_pkg::phys_reg_t    i_alu_wb_reg,
	input  logic                          i_load_wb_valid,
	input  issue_types_pkg::phys_reg_t    i_load_wb_reg,
	input  logic                          i_int_release_valid,
	input  logic [INT_IDX_W-1:0]          i_int_release_idx,
	input  logic                          i_mem_release_valid,
	input  logic [MEM_IDX_W-1:0]          i_mem_release_idx,
	input  logic [INT_IDX_W-1:0]          i_int_rd_idx,
	input  logic [MEM_IDX_W-1:0]          i_mem_rd_idx,
	output logic                          o_stall,
	output logic [INT_DEPTH-1:0]          o_int_busy,
	output logic [INT_DEPTH-1:0]          o_int_ready,
	output logic [MEM_DEPTH-1:0]          o_mem_busy,
	output logic [MEM_DEPTH-1:0]          o_mem_ready,
	output issue_types_pkg::phys_reg_t    o_int_rd_src1,
	output issue_types_pkg::phys_reg_t    o_int_rd_src2,
	output issue_types_pkg::data_t        o_int_rd_imm,
	output issue_types_pkg::active_id_t   o_int_rd_active_id,
	output issue_types_pkg::phys_reg_t    o_mem_rd_base,
	output issue_types_pkg::phys_reg_t    o_mem_rd_store_src,
	output issue_types_pkg::data_t        o_mem_rd_imm,
	output issue_types_pkg::mem_action_t  o_mem_rd_action,
	output issue_types_pkg::active_id_t   o_mem_rd_active_id
);
	import issue_cfg_pkg::*;

	logic int_we [ISSUE_WIDTH];
	logic [INT_IDX_W-1:0] int_idx [ISSUE_WIDTH];
	logic mem_we [ISSUE_WIDTH];
	logic [MEM_IDX_W-1:0] mem_idx [ISSUE_WIDTH];

	// Allocation sees the busy masks as registered
	dispatch_control #(
		.INT_DEPTH (INT_DEPTH),
		.MEM_DEPTH (MEM_DEPTH)
	) u_dispatch (
		.i_valid    (i_valid),
		.i_is_mem   (i_is_mem),
		.i_int_busy (o_int_busy),
		.i_mem_busy (o_mem_busy),
		.o_stall    (o_stall),
		.o_int_we   (int_we),
		.o_int_idx  (int_idx),
		.o_mem_we   (mem_we),
		.o_mem_idx  (mem_idx)
	);

	int_issue_queue #(
		.DEPTH (INT_DEPTH)
	) u_int_queue (
		.clk             (clk),
		.rst_n           (rst_n),
		.i_we            (int_we),
		.i_idx           (int_idx),
		.i_rs            (i_rs),
		.i_rs_ready      (i_rs_ready),
		.i_rt            (i_rt),
		.i_rt_ready      (i_rt_ready),
		.i_uses_rs       (i_uses_rs),
		.i_uses_rt       (i_uses_rt),
		.i_uses_imm      (i_uses_imm),
		.i_imm           (i_imm),
		.i_active_id     (i_active_id),
		.i_alu_wb_valid  (i_alu_wb_valid),
		.i_alu_wb_reg    (i_alu_wb_reg),
		.i_load_wb_valid (i_load_wb_valid),
		.i_load_wb_reg   (i_load_wb_reg),
		.i_release_valid (i_int_release_valid),
		.i_release_idx   (i_int_release_idx),
		.i_rd_idx        (i_int_rd_idx),
		.o_busy          (o_int_busy),
		.o_ready         (o_int_ready),
		.o_rd_src1       (o_int_rd_src1),
		.o_rd_src2       (o_int_rd_src2),
		.o_rd_imm        (o_int_rd_imm),
		.o_rd_active_id  (o_int_rd_active_id)
	);

	mem_issue_queue #(
		.DEPTH (MEM_DEPTH)
	) u_mem_queue (
		.clk             (clk),
		.rst_n           (rst_n),
		.i_we            (mem_we),
		.i_idx           (mem_idx),
		.i_rs            (i_rs),
		.i_rs_ready      (i_rs_ready),
		.i_rt            (i_rt),
		.i_rt_ready      (i_rt_ready),
		.i_uses_rs       (i_uses_rs),
		.i_uses_rt       (i_uses_rt),
		.i_imm           (i_imm),
		.i_mem_action    (i_mem_action),
		.i_active_id     (i_active_id),
		.i_alu_wb_valid  (i_alu_wb_valid),
		.i_alu_wb_reg    (i_alu_wb_reg),
		.i_load_wb_valid (i_load_wb_valid),
		.i_load_wb_reg   (i_load_wb_reg),
		.i_release_valid (i_mem_release_valid),
		.i_release_idx   (i_mem_release_idx),
		.i_rd_idx        (i_mem_rd_idx),
		.o_busy          (o_mem_busy),
		.o_ready         (o_mem_ready),
		.o_rd_base       (o_mem_rd_base),
		.o_rd_store_src  (o_mem_rd_store_src),
		.o_rd_imm        (o_mem_rd_imm),
		.o_rd_action     (o_mem_rd_action),
		.o_rd_active_id  (o_mem_rd_active_id)
	);

endmodule

`default_nettype wire

/* verilog/mem_issue_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_issue_queue #(
	parameter int DEPTH = issue_cfg_pkg::MEM_QUEUE_DEPTH_DEFAULT,
	localparam int IDX_W = $clog2(DEPTH)
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          i_we [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic [IDX_W-1:0]              i_idx [issue_cfg_pkg::ISSUE_WIDTH],
	input  issue_types_pkg::phys_reg_t    i_rs [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                          i_rs_ready [issue_cfg_pkg::ISSUE_WIDTH],
	input  issue_types_pkg::phys_reg_t    i_rt [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                          i_rt_ready [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                          i_uses_rs [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                          i_uses_rt [issue_cfg_pkg::ISSUE_WIDTH],
	input  issue_types_pkg::data_t        i_imm [issue_cfg_pkg::ISSUE_WIDTH],
	input  issue_types_pkg::mem_action_t  i_mem_action [issue_cfg_pkg::ISSUE_WIDTH],
	input  issue_types_pkg::active_id_t   i_active_id [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                          i_alu_wb_valid,
	input  issue_types_pkg::phys_reg_t    i_alu_wb_reg,
	input  logic                          i_load_wb_valid,
	input  issue_types_pkg::phys_reg_t    i_load_wb_reg,
	input  logic                          i_release_valid,
	input  logic [IDX_W-1:0]              i_release_idx,
	input  logic [IDX_W-1:0]              i_rd_idx,
	output logic [DEPTH-1:0]              o_busy,
	output logic [DEPTH-1:0]              o_ready,
	output issue_types_pkg::phys_reg_t    o_rd_base,
	output issue_types_pkg::phys_reg_t    o_rd_store_src,
	output issue_types_pkg::data_t        o_rd_imm,
	output issue_types_pkg::mem_action_t  o_rd_action,
	output issue_types_pkg::active_id_t   o_rd_active_id
);
	import issue_cfg_pkg::*;
	import issue_types_pkg::*;

	logic [DEPTH-1:0] busy;
	logic [DEPTH-1:0] rdy_base;
	logic [DEPTH-1:0] rdy_store;
	phys_reg_t base [DEPTH];
	phys_reg_t store_src [DEPTH];
	data_t imm [DEPTH];
	mem_action_t action [DEPTH];
	active_id_t active_id [DEPTH];

	function automatic logic wb_hit(input phys_reg_t r);
		return (i_alu_wb_valid && (i_alu_wb_reg == r)) ||
			(i_load_wb_valid && (i_load_wb_reg == r));
	endfunction

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy <= '0;
			rdy_base <= '0;
			rdy_store <= '0;
		end
		else
		begin
			for (int e = 0; e < DEPTH; e++)
			begin
				if (busy[e] && wb_hit(base[e]))
					rdy_base[e] <= 1'b1;
				if (busy[e] && wb_hit(store_src[e]))
					rdy_store[e] <= 1'b1; // Store data operand
			end
			if (i_release_valid)
				busy[i_release_idx] <= 1'b0;
			for (int s = 0; s < ISSUE_WIDTH; s++)
			begin
				if (i_we[s])
				begin
					busy[i_idx[s]] <= 1'b1;
					rdy_base[i_idx[s]] <= !i_uses_rs[s] || i_rs_ready[s] || wb_hit(i_rs[s]);
					rdy_store[i_idx[s]] <= !i_uses_rt[s] || i_rt_ready[s] || wb_hit(i_rt[s]);
				end
			end
		end
	end

	// Address offset is always kept
	always_ff @(posedge clk)
	begin
		for (int s = 0; s < ISSUE_WIDTH; s++)
		begin
			if (i_we[s])
			begin
				base[i_idx[s]] <= i_rs[s];
				store_src[i_idx[s]] <= i_rt[s];
				imm[i_idx[s]] <= i_imm[s];
				action[i_idx[s]] <= i_mem_action[s];
				active_id[i_idx[s]] <= i_active_id[s];
			end
		end
	end

	assign o_busy = busy;
	assign o_ready = busy & rdy_base & rdy_store;

	assign o_rd_base = base[i_rd_idx];
	assign o_rd_store_src = store_src[i_rd_idx];
	assign o_rd_imm = imm[i_rd_idx];
	assign o_rd_action = action[i_rd_idx];
	assign o_rd_active_id = active_id[i_rd_idx];

	assert property (@(posedge clk) disable iff (!rst_n)
		i_release_valid |-> busy[i_release_idx])
		else $error("mem_issue_queue: release of idle entry %0d", i_release_idx);

endmodule

`default_nettype wire

/* verilog/int_issue_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module int_issue_queue #(
	parameter int DEPTH = issue_cfg_pkg::INT_QUEUE_DEPTH_DEFAULT,
	localparam int IDX_W = $clog2(DEPTH)
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         i_we [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic [IDX_W-1:0]             i_idx [issue_cfg_pkg::ISSUE_WIDTH],
	input  issue_types_pkg::phys_reg_t   i_rs [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                         i_rs_ready [issue_cfg_pkg::ISSUE_WIDTH],
	input  issue_types_pkg::phys_reg_t   i_rt [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                         i_rt_ready [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                         i_uses_rs [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                         i_uses_rt [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                         i_uses_imm [issue_cfg_pkg::ISSUE_WIDTH],
	input  issue_types_pkg::data_t       i_imm [issue_cfg_pkg::ISSUE_WIDTH],
	input  issue_types_pkg::active_id_t  i_active_id [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                         i_alu_wb_valid,
	input  issue_types_pkg::phys_reg_t   i_alu_wb_reg,
	input  logic                         i_load_wb_valid,
	input  issue_types_pkg::phys_reg_t   i_load_wb_reg,
	input  logic                         i_release_valid,
	input  logic [IDX_W-1:0]             i_release_idx,
	input  logic [IDX_W-1:0]             i_rd_idx,
	output logic [DEPTH-1:0]             o_busy,
	output logic [DEPTH-1:0]             o_ready,
	output issue_types_pkg::phys_reg_t   o_rd_src1,
	output issue_types_pkg::phys_reg_t   o_rd_src2,
	output issue_types_pkg::data_t       o_rd_imm,
	output issue_types_pkg::active_id_t  o_rd_active_id
);
	import issue_cfg_pkg::*;
	import issue_types_pkg::*;

	logic [DEPTH-1:0] busy;
	logic [DEPTH-1:0] rdy_src1;
	logic [DEPTH-1:0] rdy_src2;
	phys_reg_t src1 [DEPTH];
	phys_reg_t src2 [DEPTH];
	data_t imm [DEPTH];
	active_id_t active_id [DEPTH];

	// Either write-back port producing this register
	function automatic logic wb_hit(input phys_reg_t r);
		return (i_alu_wb_valid && (i_alu_wb_reg == r)) ||
			(i_load_wb_valid && (i_load_wb_reg == r));
	endfunction

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy <= '0;
			rdy_src1 <= '0;
			rdy_src2 <= '0;
		end
		else
		begin
			for (int e = 0; e < DEPTH; e++)
			begin
				if (busy[e] && wb_hit(src1[e]))
					rdy_src1[e] <= 1'b1;
				if (busy[e] && wb_hit(src2[e]))
					rdy_src2[e] <= 1'b1;
			end
			if (i_release_valid)
				busy[i_release_idx] <= 1'b0;
			for (int s = 0; s < ISSUE_WIDTH; s++)
			begin
				if (i_we[s])
				begin
					busy[i_idx[s]] <= 1'b1;
					// Unused source counts as ready, same-cycle write-back also wakes it
					rdy_src1[i_idx[s]] <= !i_uses_rs[s] || i_rs_ready[s] || wb_hit(i_rs[s]);
					rdy_src2[i_idx[s]] <= !i_uses_rt[s] || i_rt_ready[s] || wb_hit(i_rt[s]);
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		for (int s = 0; s < ISSUE_WIDTH; s++)
		begin
			if (i_we[s])
			begin
				src1[i_idx[s]] <= i_rs[s];
				src2[i_idx[s]] <= i_rt[s];
				imm[i_idx[s]] <= i_uses_imm[s] ? i_imm[s] : '0;
				active_id[i_idx[s]] <= i_active_id[s];
			end
		end
	end

	assign o_busy = busy;
	assign o_ready = busy & rdy_src1 & rdy_src2;

	assign o_rd_src1 = src1[i_rd_idx];
	assign o_rd_src2 = src2[i_rd_idx];
	assign o_rd_imm = imm[i_rd_idx];
	assign o_rd_active_id = active_id[i_rd_idx];

	// Execution side may only free an entry it was issued
	assert property (@(posedge clk) disable iff (!rst_n)
		i_release_valid |-> busy[i_release_idx])
		else $error("int_issue_queue: release of idle entry %0d", i_release_idx);

endmodule

`default_nettype wire

/* verilog/dispatch_control.sv */
`timescale 1ns/10ps
`default_nettype none

module dispatch_control #(
	parameter int INT_DEPTH = issue_cfg_pkg::INT_QUEUE_DEPTH_DEFAULT,
	parameter int MEM_DEPTH = issue_cfg_pkg::MEM_QUEUE_DEPTH_DEFAULT,
	localparam int INT_IDX_W = $clog2(INT_DEPTH),
	localparam int MEM_IDX_W = $clog2(MEM_DEPTH)
) (
	input  logic                 i_valid [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic                 i_is_mem [issue_cfg_pkg::ISSUE_WIDTH],
	input  logic [INT_DEPTH-1:0] i_int_busy,
	input  logic [MEM_DEPTH-1:0] i_mem_busy,
	output logic                 o_stall,
	output logic                 o_int_we [issue_cfg_pkg::ISSUE_WIDTH],
	output logic [INT_IDX_W-1:0] o_int_idx [issue_cfg_pkg::ISSUE_WIDTH],
	output logic                 o_mem_we [issue_cfg_pkg::ISSUE_WIDTH],
	output logic [MEM_IDX_W-1:0] o_mem_idx [issue_cfg_pkg::ISSUE_WIDTH]
);
	import issue_cfg_pkg::*;

	logic [INT_IDX_W-1:0] int_lo;
	logic [INT_IDX_W-1:0] int_hi;
	logic [MEM_IDX_W-1:0] mem_lo;
	logic [MEM_IDX_W-1:0] mem_hi;
	logic [1:0] int_free;
	logic [1:0] mem_free;
	logic [1:0] int_need;
	logic [1:0] mem_need;

	// Bottom-up and top-down searches for a free entry
	always_comb
	begin
		int_lo = '0;
		int_hi = '0;
		for (int e = INT_DEPTH - 1; e >= 0; e--)
			if (!i_int_busy[e])
				int_lo = INT_IDX_W'(e);
		for (int e = 0; e < INT_DEPTH; e++)
			if (!i_int_busy[e])
				int_hi = INT_IDX_W'(e);
	end

	always_comb
	begin
		mem_lo = '0;
		mem_hi = '0;
		for (int e = MEM_DEPTH - 1; e >= 0; e--)
			if (!i_mem_busy[e])
				mem_lo = MEM_IDX_W'(e);
		for (int e = 0; e < MEM_DEPTH; e++)
			if (!i_mem_busy[e])
				mem_hi = MEM_IDX_W'(e);
	end

	// Free count only needs to reach 2
	assign int_free = (&i_int_busy) ? 2'd0 : (int_lo == int_hi) ? 2'd1 : 2'd2;
	assign mem_free = (&i_mem_busy) ? 2'd0 : (mem_lo == mem_hi) ? 2'd1 : 2'd2;

	always_comb
	begin
		int_need = '0;
		mem_need = '0;
		for (int s = 0; s < ISSUE_WIDTH; s++)
		begin
			if (i_valid[s] && i_is_mem[s])
				mem_need = mem_need + 2'd1;
			else if (i_valid[s])
				int_need = int_need + 2'd1;
		end
	end

	assign o_stall = (int_need > int_free) || (mem_need > mem_free); // Whole group waits

	always_comb
	begin
		for (int s = 0; s < ISSUE_WIDTH; s++)
		begin
			o_int_we[s] = !o_stall && i_valid[s] && !i_is_mem[s];
			o_mem_we[s] = !o_stall && i_valid[s] && i_is_mem[s];
		end
		o_int_idx[0] = int_lo; // Slot 0 fills from the bottom
		o_int_idx[1] = int_hi;
		o_mem_idx[0] = mem_lo;
		o_mem_idx[1] = mem_hi;
	end

	// Two writes into one queue must never land on the same entry
	always_comb
	begin
		assert (!(o_int_we[0] && o_int_we[1]) || (o_int_idx[0] != o_int_idx[1]))
			else $error("dispatch_control: both slots got int entry %0d", o_int_idx[0]);
		assert (!(o_mem_we[0] && o_mem_we[1]) || (o_mem_idx[0] != o_mem_idx[1]))
			else $error("dispatch_control: both slots got mem entry %0d", o_mem_idx[0]);
	end

endmodule

`default_nettype wire

/* verilog/issue_types_pkg.sv */
`default_nettype none

package issue_types_pkg;

	// Physical register number after rename
	typedef logic [5:0] phys_reg_t;

	// Active list slot of the instruction
	typedef logic [4:0] active_id_t;

	// Immediate operand
	typedef logic [31:0] data_t;

	// Load or store
	typedef enum logic
	{
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_action_t;

endpackage

`default_nettype wire

/* verilog/issue_cfg_pkg.sv */
`default_nettype none

package issue_cfg_pkg;

	// Instructions offered per dispatch group
	// Lowest/highest allocation covers exactly two slots
	localparam int ISSUE_WIDTH = 2;

	// Default queue depths, overridden through issue_top parameters
	localparam int INT_QUEUE_DEPTH_DEFAULT = 8;
	localparam int MEM_QUEUE_DEPTH_DEFAULT = 4;

endpackage

`default_nettype wire
